// File: bgLoadPkg.sv
package bgLoadPkg;

	// frame geometry, one byte per pixel, two pixels per SRAM word
	localparam int frameWords = 153600;
	// one spare word after each frame holds the end marker
	localparam int bgStride = frameWords + 1;

	// word address widths
	localparam int sramAddrWidth = 20;
	localparam int fbAddrWidth = 18;

	// top nibble of a word that ends a background
	localparam logic [3:0] markerTag = 4'hF;

	// host handshake states
	localparam logic [1:0] hostIdle = 2'd0;
	localparam logic [1:0] hostCopying = 2'd1;
	localparam logic [1:0] hostAcked = 2'd2;

	// copy engine states
	localparam logic [2:0] engIdle = 3'd0;
	localparam logic [2:0] engRequest = 3'd1;
	localparam logic [2:0] engEmit = 3'd2;
	localparam logic [2:0] engRelease = 3'd3;
	localparam logic [2:0] engFinished = 3'd4;

	// one SRAM word, seen either as two pixels or as an end marker
	typedef union packed {
		struct packed {
			logic [7:0] pixHi;
			logic [7:0] pixLo;
		} pix;
		struct packed {
			logic [3:0] tag;
			logic [11:0] payload;
		} marker;
	} sramWord_u;

endpackage

// File: bgSelectDecode.sv
`timescale 1ns/1ps

module bgSelectDecode import bgLoadPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic loadReq,
	input logic [1:0] bgSel,
	input logic copyDone,
	output logic loadAck,
	output logic start,
	output logic [sramAddrWidth-1:0] baseAddr
);

	logic [1:0] hostState;

	// host four-phase handshake
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			hostState <= hostIdle;
			loadAck <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			case (hostState)
				hostIdle:
					// new request, kick the engine next cycle
					if (loadReq)
					begin
						start <= 1'b1;
						hostState <= hostCopying;
					end
				hostCopying:
					// copyDone from the last copy is still up while start is high
					if (copyDone && !start)
					begin
						loadAck <= 1'b1;
						hostState <= hostAcked;
					end
				hostAcked:
					// a held request just keeps the ack up
					if (!loadReq)
					begin
						loadAck <= 1'b0;
						hostState <= hostIdle;
					end
				default:
					hostState <= hostIdle;
			endcase
		end
	end

	// background base, sampled only when the request is taken
	always_ff @(posedge Clk)
	begin
		if (hostState == hostIdle && loadReq)
			baseAddr <= sramAddrWidth'(bgSel) * sramAddrWidth'(bgStride);
	end

	// ack only while the engine still holds its finished copy
	ackAfterDone: assert property (@(posedge Clk) disable iff (!rstN)
		loadAck |-> copyDone);

endmodule

// File: bgCopyEngine.sv
`timescale 1ns/1ps

module bgCopyEngine import bgLoadPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic start,
	input logic [sramAddrWidth-1:0] baseAddr,
	input logic sramAck,
	input logic [15:0] sramData,
	output logic sramReq,
	output logic [sramAddrWidth-1:0] sramAddr,
	output logic wordValid,
	output logic [15:0] wordData,
	output logic clear,
	output logic copyDone
);

	logic [2:0] state;
	// words handed to the write stage so far
	logic [sramAddrWidth-1:0] emitCount;
	// set once the copy has to end after this handshake
	logic stopping;
	sramWord_u capWord;
	logic isMarker;
	logic lastWord;

	// look at the incoming word through the marker view
	assign capWord = sramData;
	assign isMarker = (capWord.marker.tag == markerTag);
	// last slot of a full frame
	assign lastWord = (emitCount == sramAddrWidth'(frameWords - 1));

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= engIdle;
			sramReq <= 1'b0;
			sramAddr <= '0;
			wordValid <= 1'b0;
			clear <= 1'b0;
			copyDone <= 1'b0;
			stopping <= 1'b0;
			emitCount <= '0;
		end
		else
		begin
			// strobes default low
			wordValid <= 1'b0;
			clear <= 1'b0;
			if (start)
			begin
				// new copy from the top of the chosen background
				sramAddr <= baseAddr;
				emitCount <= '0;
				stopping <= 1'b0;
				copyDone <= 1'b0;
				clear <= 1'b1;
				if (state == engIdle || state == engFinished)
				begin
					sramReq <= 1'b1;
					state <= engRequest;
				end
				else
					// old handshake still closing, release issues the request
					state <= engRelease;
			end
			else
			begin
				case (state)
					engRequest:
						if (sramAck)
						begin
							// data captured, drop the request
							sramReq <= 1'b0;
							if (isMarker)
							begin
								// marker ends the copy, nothing written
								copyDone <= 1'b1;
								stopping <= 1'b1;
							end
							else
								wordValid <= 1'b1;
							state <= engEmit;
						end
					engEmit:
					begin
						if (!stopping)
						begin
							emitCount <= emitCount + 1'b1;
							sramAddr <= sramAddr + 1'b1;
							// full frame without a marker
							if (lastWord)
							begin
								copyDone <= 1'b1;
								stopping <= 1'b1;
							end
						end
						state <= engRelease;
					end
					engRelease:
						// SRAM must drop its ack before the next request
						if (!sramAck)
						begin
							if (stopping)
								state <= engFinished;
							else
							begin
								sramReq <= 1'b1;
								state <= engRequest;
							end
						end
					default:
						;
				endcase
			end
		end
	end

	// payload register, loaded on the capture cycle
	always_ff @(posedge Clk)
	begin
		if (state == engRequest && sramAck)
			wordData <= capWord;
	end

	// four-phase rule, request stays up until the ack is seen
	reqHeldForAck: assert property (@(posedge Clk) disable iff (!rstN)
		$fell(sramReq) |-> $past(sramAck));

	// address may not move under an open request
	addrStableInReq: assert property (@(posedge Clk) disable iff (!rstN)
		sramReq && $past(sramReq) |-> $stable(sramAddr));

endmodule

// File: fbWriteStage.sv
`timescale 1ns/1ps

module fbWriteStage import bgLoadPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic clear,
	input logic wordValid,
	input logic [15:0] wordData,
	output logic fbWe,
	output logic [fbAddrWidth-1:0] fbAddr,
	output logic [15:0] fbData,
	output logic [fbAddrWidth-1:0] wordCount
);

	sramWord_u inWord;

	// pixel view of the word from the engine
	assign inWord = wordData;

	// write strobe, address and count
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			fbWe <= 1'b0;
			fbAddr <= '0;
			wordCount <= '0;
		end
		else
		begin
			fbWe <= wordValid;
			if (clear)
			begin
				// new background starts at frame buffer word 0
				fbAddr <= '0;
				wordCount <= '0;
			end
			else
			begin
				// count the write as it is issued
				if (wordValid)
					wordCount <= wordCount + 1'b1;
				// address moves on after the write
				if (fbWe)
					fbAddr <= fbAddr + 1'b1;
			end
		end
	end

	// high pixel goes to the upper byte
	always_ff @(posedge Clk)
	begin
		if (wordValid)
			fbData <= {inWord.pix.pixHi, inWord.pix.pixLo};
	end

	// the engine must stop at one frame
	writeInFrame: assert property (@(posedge Clk) disable iff (!rstN)
		fbWe |-> fbAddr < fbAddrWidth'(frameWords));

endmodule

// File: bgLoader.sv
`timescale 1ns/1ps

module bgLoader import bgLoadPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic loadReq,
	input logic [1:0] bgSel,
	input logic sramAck,
	input logic [15:0] sramData,
	output logic loadAck,
	output logic sramReq,
	output logic [sramAddrWidth-1:0] sramAddr,
	output logic fbWe,
	output logic [fbAddrWidth-1:0] fbAddr,
	output logic [15:0] fbData,
	output logic [fbAddrWidth-1:0] wordCount
);

	// decode to engine
	logic start;
	logic [sramAddrWidth-1:0] baseAddr;
	// engine to decode
	logic copyDone;
	// engine to write stage
	logic wordValid;
	logic [15:0] wordData;
	logic clear;

	// host handshake and base address
	bgSelectDecode i_bgSelectDecode (
		.Clk(Clk),
		.rstN(rstN),
		.loadReq(loadReq),
		.bgSel(bgSel),
		.copyDone(copyDone),
		.loadAck(loadAck),
		.start(start),
		.baseAddr(baseAddr)
	);

	// SRAM reader
	bgCopyEngine i_bgCopyEngine (
		.Clk(Clk),
		.rstN(rstN),
		.start(start),
		.baseAddr(baseAddr),
		.sramAck(sramAck),
		.sramData(sramData),
		.sramReq(sramReq),
		.sramAddr(sramAddr),
		.wordValid(wordValid),
		.wordData(wordData),
		.clear(clear),
		.copyDone(copyDone)
	);

	// frame buffer write port and count
	fbWriteStage i_fbWriteStage (
		.Clk(Clk),
		.rstN(rstN),
		.clear(clear),
		.wordValid(wordValid),
		.wordData(wordData),
		.fbWe(fbWe),
		.fbAddr(fbAddr),
		.fbData(fbData),
		.wordCount(wordCount)
	);

endmodule

// File: bgLoaderCheck.sv
`timescale 1ns/1ps

module bgLoaderCheck import bgLoadPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic loadReq,
	input logic loadAck,
	input logic sramReq,
	input logic fbWe,
	input logic [fbAddrWidth-1:0] fbAddr,
	input logic [15:0] fbData,
	input logic [fbAddrWidth-1:0] wordCount,
	input logic [15:0] expWord,
	input int expCount,
	output int writeIndex,
	output int errCount
);

	logic prevAck;
	logic prevReq;
	// nothing requested since reset
	logic quiet;

	always @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			writeIndex <= 0;
			errCount = 0;
			prevAck <= 1'b0;
			prevReq <= 1'b0;
			quiet <= 1'b1;
		end
		else
		begin
			prevAck <= loadAck;
			prevReq <= loadReq;
			if (loadReq)
				quiet <= 1'b0;
			// outputs stay low until the host asks
			if (quiet && !loadReq && (loadAck || sramReq || fbWe))
			begin
				$display("Fail idle outputs: loadAck %h sramReq %h fbWe %h expected 0",
					loadAck, sramReq, fbWe);
				errCount++;
			end
			if (fbWe)
			begin
				if (loadAck)
				begin
					$display("frame buffer write seen while loadAck is high");
					errCount++;
				end
				if (fbAddr != fbAddrWidth'(writeIndex))
				begin
					$display("Fail fbAddr: got %h expected %h", fbAddr, writeIndex);
					errCount++;
				end
				if (fbData != expWord)
				begin
					$display("Fail fbData at word %0d: got %h expected %h",
						writeIndex, fbData, expWord);
					errCount++;
				end
				writeIndex <= writeIndex + 1;
			end
			else if (loadReq && !prevReq)
				writeIndex <= 0;
			// count is final once the ack rises
			if (loadAck && !prevAck)
			begin
				if (wordCount != fbAddrWidth'(expCount))
				begin
					$display("Fail wordCount: got %h expected %h", wordCount, expCount);
					errCount++;
				end
				if (writeIndex != expCount)
				begin
					$display("Fail fbWe count: got %h expected %h", writeIndex, expCount);
					errCount++;
				end
			end
			if (prevAck && !loadAck && prevReq)
			begin
				$display("loadAck dropped while loadReq was still high");
				errCount++;
			end
			if (loadAck && sramReq)
			begin
				$display("new SRAM request while loadAck is high");
				errCount++;
			end
		end
	end

endmodule

// File: bgLoaderTb.sv
`timescale 1ns/1ps

module bgLoaderTb import bgLoadPkg::*; ();

	logic Clk;
	logic rstN;
	logic loadReq;
	logic [1:0] bgSel;
	logic sramAck;
	logic [15:0] sramData;
	logic loadAck;
	logic sramReq;
	logic [sramAddrWidth-1:0] sramAddr;
	logic fbWe;
	logic [fbAddrWidth-1:0] fbAddr;
	logic [15:0] fbData;
	logic [fbAddrWidth-1:0] wordCount;

	// SRAM model
	logic [15:0] sramMem [0:(1 << sramAddrWidth) - 1];
	int seed = 72;
	int sramPhase;
	int holdLeft;
	// a full frame takes at most about 12 cycles per word
	int ackTimeout = 3000000;
	int dropTimeout = 20;

	// reference state shared with the checker
	int curBg;
	int expCount;
	logic [15:0] expWord;
	int writeIndex;
	int checkErrors;
	int hostErrors;

	// expected frame buffer word, high pixel in the upper byte
	function automatic logic [15:0] expectedWord(input int bg, input int idx);
		sramWord_u w;
		logic [sramAddrWidth-1:0] addr;
		addr = sramAddrWidth'(bg * bgStride + idx);
		w = sramMem[addr];
		return {w.pix.pixHi, w.pix.pixLo};
	endfunction

	// words before the first marker, capped at one frame
	function automatic int expectedCount(input int bg);
		logic [15:0] w;
		for (int i = 0; i < frameWords; i++)
		begin
			w = expectedWord(bg, i);
			if (w[15:12] == markerTag)
				return i;
		end
		return frameWords;
	endfunction

	assign expWord = expectedWord(curBg, writeIndex);

	bgLoader i_bgLoader (.*);

	bgLoaderCheck i_bgLoaderCheck (
		.Clk(Clk),
		.rstN(rstN),
		.loadReq(loadReq),
		.loadAck(loadAck),
		.sramReq(sramReq),
		.fbWe(fbWe),
		.fbAddr(fbAddr),
		.fbData(fbData),
		.wordCount(wordCount),
		.expWord(expWord),
		.expCount(expCount),
		.writeIndex(writeIndex),
		.errCount(checkErrors)
	);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// end marker at word pos of background bg
	task automatic placeMarker(input int bg, input int pos);
		logic [sramAddrWidth-1:0] addr;
		addr = sramAddrWidth'(bg * bgStride + pos);
		sramMem[addr] = {markerTag, 12'(pos)};
	endtask

	// SRAM fill, then the four-phase responder with 0 to 3 cycles on each edge
	initial
	begin
		logic [sramAddrWidth-1:0] fillAddr;
		sramAck = 1'b0;
		sramData = '0;
		sramPhase = 0;
		holdLeft = 0;
		for (int a = 0; a < (1 << sramAddrWidth); a++)
		begin
			fillAddr = sramAddrWidth'(a);
			sramMem[fillAddr] = 16'($random(seed));
			// no stray markers in the random data
			if (sramMem[fillAddr][15:12] == markerTag)
				sramMem[fillAddr][15:12] = 4'h7;
		end
		// background 2 keeps no marker at all
		placeMarker(0, 37);
		placeMarker(1, 0);
		placeMarker(3, 500);
		forever
		begin
			@(posedge Clk);
			#1;
			if (sramPhase == 0 && sramReq)
			begin
				holdLeft = $unsigned($random(seed)) % 4;
				sramPhase = 1;
			end
			else if (sramPhase == 2 && !sramReq)
			begin
				holdLeft = $unsigned($random(seed)) % 4;
				sramPhase = 3;
			end
			if (sramPhase == 1 || sramPhase == 3)
			begin
				if (holdLeft > 0)
					holdLeft--;
				else if (sramPhase == 1)
				begin
					sramData = sramMem[sramAddr];
					sramAck = 1'b1;
					sramPhase = 2;
				end
				else
				begin
					sramAck = 1'b0;
					sramPhase = 0;
				end
			end
		end
	end

	// one full host handshake, ack held for holdCycles before the request drops
	task automatic loadBackground(input int bg, input int holdCycles);
		int waited;
		curBg = bg;
		expCount = expectedCount(bg);
		bgSel = 2'(bg);
		loadReq = 1'b1;
		repeat (2) @(posedge Clk);
		#1;
		// bgSel is sampled on the accept cycle only
		bgSel = ~bgSel;
		waited = 0;
		while (!loadAck && waited < ackTimeout)
		begin
			@(posedge Clk);
			#1;
			waited++;
		end
		if (!loadAck)
		begin
			$display("timeout waiting for loadAck on background %0d", bg);
			hostErrors++;
		end
		else
		begin
			repeat (holdCycles) @(posedge Clk);
			#1;
			loadReq = 1'b0;
			waited = 0;
			while (loadAck && waited < dropTimeout)
			begin
				@(posedge Clk);
				#1;
				waited++;
			end
			if (loadAck)
			begin
				$display("loadAck stayed high after loadReq dropped, background %0d", bg);
				hostErrors++;
			end
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		loadReq = 1'b0;
		bgSel = 2'd0;
		curBg = 0;
		expCount = 0;
		hostErrors = 0;
		repeat (3) @(posedge Clk);
		#1;
		rstN = 1'b1;
		// quiet cycles before the first request
		repeat (6) @(posedge Clk);
		#1;
		loadBackground(0, 3);
		if (hostErrors == 0)
			loadBackground(1, 1);
		if (hostErrors == 0)
			loadBackground(2, 2);
		if (hostErrors == 0)
			loadBackground(3, 4);
		// same background again under a new delay sequence
		if (hostErrors == 0)
			loadBackground(0, 5);
		repeat (4) @(posedge Clk);
		$display("errors: checker %0d, host %0d", checkErrors, hostErrors);
		if (checkErrors == 0 && hostErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: bgLoader.f
bgLoadPkg.sv
bgSelectDecode.sv
bgCopyEngine.sv
fbWriteStage.sv
bgLoader.sv
bgLoaderCheck.sv
bgLoaderTb.sv

// File: Makefile
TOP = bgLoaderTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

obj_dir/V$(TOP): bgLoader.f $(wildcard *.sv)
	verilator --binary --timing --assert -f bgLoader.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall bgLoadPkg.sv bgSelectDecode.sv bgCopyEngine.sv \
		fbWriteStage.sv bgLoader.sv --top-module bgLoader

clean:
	rm -rf obj_dir
